// ==== rtl/mul16_macros.svh ====
//**************************************************************************
// Multiplier width macros
//**************************************************************************

`ifndef MUL16_MACROS_SVH
`define MUL16_MACROS_SVH

// Full operand width
`define MUL16_OPERAND_W 16

// One operand byte, also the byte multiplier input width
`define MUL16_HALF_W 8

// Lookahead group size in the 32-bit adder
`define MUL16_GROUP_W 4

`endif

// ==== rtl/mul16_pkg.sv ====
//**************************************************************************
// Multiplier datapath types
//**************************************************************************

`include "mul16_macros.svh"

package mul16_pkg;

  // One multiplier operand
  typedef logic [`MUL16_OPERAND_W-1:0] operand_t;

  // High or low byte of an operand
  typedef logic [`MUL16_HALF_W-1:0] half_t;

  // Byte by byte partial product
  typedef logic [2*`MUL16_HALF_W-1:0] pp_t;

  // Full product, also the adder operand width
  typedef logic [2*`MUL16_OPERAND_W-1:0] product_t;

endpackage

// ==== rtl/mul8_array.sv ====
//**************************************************************************
// Exact 8x8 array multiplier
//**************************************************************************

`timescale 1ns/10ps

module mul8_array (
  input  mul16_pkg::half_t x,
  input  mul16_pkg::half_t y,
  output mul16_pkg::pp_t   p
);

  import mul16_pkg::*;

  // AND terms, t[j][i] = x[i] & y[j]
  half_t      t [8];

  // Carry-save rows, index i of row r has weight i + r
  logic [6:0] s [1:7];
  logic [6:0] c [1:7];

  // Final carry-propagate row
  logic [6:0] fin_a;
  logic [6:0] fin_s;
  logic [7:1] fin_c;

  for (genvar j = 0; j < 8; j++) begin : g_and_row
    assign t[j] = x & {8{y[j]}};
  end

  // First row only has two terms per column
  assign s[1] = t[0][7:1] ^ t[1][6:0];
  assign c[1] = t[0][7:1] & t[1][6:0];

  for (genvar r = 2; r < 8; r++) begin : g_fa_row
    logic [6:0] a_in;
    logic [6:0] half_sum;

    // Top column of each row takes the leftover AND term from above
    assign a_in     = {t[r-1][7], s[r-1][6:1]};
    assign half_sum = a_in ^ t[r][6:0];
    assign s[r]     = half_sum ^ c[r-1];
    assign c[r]     = (a_in & t[r][6:0]) | (half_sum & c[r-1]);
  end

  assign fin_a = {t[7][7], s[7][6:1]};

  // Bit 8 has no incoming carry
  assign fin_s[0] = fin_a[0] ^ c[7][0];
  assign fin_c[1] = fin_a[0] & c[7][0];

  for (genvar i = 1; i < 7; i++) begin : g_ripple
    logic half_sum;

    assign half_sum   = fin_a[i] ^ c[7][i];
    assign fin_s[i]   = half_sum ^ fin_c[i];
    assign fin_c[i+1] = (fin_a[i] & c[7][i]) | (half_sum & fin_c[i]);
  end

  // Low byte falls out of the rows, one bit per row
  assign p[0] = t[0][0];

  for (genvar k = 1; k < 8; k++) begin : g_low_bits
    assign p[k] = s[k][0];
  end

  assign p[15:8] = {fin_c[7], fin_s};

endmodule

// ==== rtl/cla_adder32.sv ====
//**************************************************************************
// 32-bit carry-lookahead adder
//**************************************************************************

`timescale 1ns/10ps

`include "mul16_macros.svh"

module cla_adder32 (
  input  mul16_pkg::product_t x,
  input  mul16_pkg::product_t y,
  output mul16_pkg::product_t sum
);

  import mul16_pkg::*;

  localparam int GW      = `MUL16_GROUP_W;
  localparam int NGROUPS = $bits(product_t) / GW;

  // Per-bit propagate and generate
  product_t           p;
  product_t           g;

  // Group propagate, group generate and carry into each group
  logic [NGROUPS-1:0] gp;
  logic [NGROUPS-1:0] gg;
  logic [NGROUPS-1:0] gc;

  assign p = x ^ y;
  assign g = x & y;

  // Second level, flattened sum of products per group carry
  always_comb begin
    logic term;

    gc[0] = 1'b0;
    for (int k = 1; k < NGROUPS; k++) begin
      gc[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

  for (genvar k = 0; k < NGROUPS; k++) begin : g_group
    localparam int LSB = k * GW;

    logic [GW-1:0] pb;
    logic [GW-1:0] gb;
    logic [GW-1:0] cb;
    logic          grp_g;

    assign pb    = p[LSB +: GW];
    assign gb    = g[LSB +: GW];
    assign gp[k] = &pb;
    assign gg[k] = grp_g;

    always_comb begin
      grp_g = 1'b0;
      for (int b = 0; b < GW; b++) begin
        grp_g = gb[b] | (pb[b] & grp_g);
      end
    end

    // Carries inside the group start from the lookahead carry
    always_comb begin
      cb[0] = gc[k];
      for (int b = 1; b < GW; b++) begin
        cb[b] = gb[b-1] | (pb[b-1] & cb[b-1]);
      end
    end

    assign sum[LSB +: GW] = pb ^ cb;
  end

endmodule

// ==== rtl/partial_product_stage.sv ====
//**************************************************************************
// Partial product pipeline stage
//**************************************************************************

`timescale 1ns/10ps

`include "mul16_macros.svh"

module partial_product_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  mul16_pkg::operand_t a,
  input  mul16_pkg::operand_t b,
  output logic                pp_valid,
  output mul16_pkg::pp_t      pp_ll,
  output mul16_pkg::pp_t      pp_lh,
  output mul16_pkg::pp_t      pp_hl,
  output mul16_pkg::pp_t      pp_hh
);

  import mul16_pkg::*;

  half_t a_lo;
  half_t a_hi;
  half_t b_lo;
  half_t b_hi;

  pp_t   ll;
  pp_t   lh;
  pp_t   hl;
  pp_t   hh;

  assign a_lo = a[`MUL16_HALF_W-1:0];
  assign a_hi = a[2*`MUL16_HALF_W-1:`MUL16_HALF_W];
  assign b_lo = b[`MUL16_HALF_W-1:0];
  assign b_hi = b[2*`MUL16_HALF_W-1:`MUL16_HALF_W];

  mul8_array mul_ll (.x(a_lo), .y(b_lo), .p(ll));
  mul8_array mul_lh (.x(a_lo), .y(b_hi), .p(lh));
  mul8_array mul_hl (.x(a_hi), .y(b_lo), .p(hl));
  mul8_array mul_hh (.x(a_hi), .y(b_hi), .p(hh));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
      pp_ll    <= '0;
      pp_lh    <= '0;
      pp_hl    <= '0;
      pp_hh    <= '0;
    end else begin
      pp_valid <= in_valid;
      // Products hold while no pair is accepted
      if (in_valid) begin
        pp_ll <= ll;
        pp_lh <= lh;
        pp_hl <= hl;
        pp_hh <= hh;
      end
    end
  end

endmodule

// ==== rtl/product_sum_stage.sv ====
//**************************************************************************
// Partial product sum pipeline stage
//**************************************************************************

`timescale 1ns/10ps

`include "mul16_macros.svh"

module product_sum_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pp_valid,
  input  mul16_pkg::pp_t      pp_ll,
  input  mul16_pkg::pp_t      pp_lh,
  input  mul16_pkg::pp_t      pp_hl,
  input  mul16_pkg::pp_t      pp_hh,
  output logic                out_valid,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  product_t llhh;
  product_t lh_shifted;
  product_t hl_shifted;
  product_t first_sum;
  product_t full_sum;

  // hh and ll never overlap, so they share one adder operand
  assign llhh       = {pp_hh, pp_ll};
  assign lh_shifted = {{`MUL16_HALF_W{1'b0}}, pp_lh, {`MUL16_HALF_W{1'b0}}};
  assign hl_shifted = {{`MUL16_HALF_W{1'b0}}, pp_hl, {`MUL16_HALF_W{1'b0}}};

  cla_adder32 add_lh (.x(llhh),      .y(lh_shifted), .sum(first_sum));
  cla_adder32 add_hl (.x(first_sum), .y(hl_shifted), .sum(full_sum));

  // Full product of two 16-bit operands fits in 32 bits, no carry out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= pp_valid;
      if (pp_valid) begin
        product <= full_sum;
      end
    end
  end

endmodule

// ==== rtl/mul16_top.sv ====
//**************************************************************************
// Pipelined 16x16 multiplier
//**************************************************************************

`timescale 1ns/10ps

module mul16_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  mul16_pkg::operand_t a,
  input  mul16_pkg::operand_t b,
  output logic                out_valid,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  logic pp_valid;
  pp_t  pp_ll;
  pp_t  pp_lh;
  pp_t  pp_hl;
  pp_t  pp_hh;

  // Stage 1, byte products
  partial_product_stage pp_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp_valid (pp_valid),
    .pp_ll    (pp_ll),
    .pp_lh    (pp_lh),
    .pp_hl    (pp_hl),
    .pp_hh    (pp_hh)
  );

  // Stage 2, aligned sum
  product_sum_stage sum_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .pp_valid  (pp_valid),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

// ==== verif/mul16_tb.sv ====
//**************************************************************************
// Pipelined multiplier testbench
//**************************************************************************

`timescale 1ns/10ps

module mul16_tb;

  import mul16_pkg::*;

  localparam int NUM_VECTORS    = 16;
  localparam int NUM_RANDOM     = 200;
  localparam int LATENCY        = 2;
  localparam int TIMEOUT_CYCLES = (NUM_VECTORS + NUM_RANDOM) * 2 + 50;

  // Each row is {a, b, expected product}
  logic [63:0] vectors [NUM_VECTORS] = '{
    {16'h0000, 16'h1234, 32'h0000_0000},
    {16'hABCD, 16'h0000, 32'h0000_0000},
    {16'hFFFF, 16'hFFFF, 32'hFFFE_0001},
    {16'h0001, 16'h0001, 32'h0000_0001},
    // ll, lh, hl and hh one at a time
    {16'h00FF, 16'h00FF, 32'h0000_FE01},
    {16'h00FF, 16'hFF00, 32'h00FE_0100},
    {16'hFF00, 16'h00FF, 32'h00FE_0100},
    {16'hFF00, 16'hFF00, 32'hFE01_0000},
    {16'h1234, 16'h5678, 32'h0626_0060},
    // Long carry chains through the adders
    {16'hFFFF, 16'h8001, 32'h8000_7FFF},
    {16'h00FF, 16'hFFFF, 32'h00FE_FF01},
    {16'h8001, 16'h8001, 32'h4001_0001},
    {16'h7FFF, 16'h7FFF, 32'h3FFF_0001},
    {16'hAAAA, 16'h5555, 32'h38E3_1C72},
    {16'hFFFF, 16'h0001, 32'h0000_FFFF},
    {16'h0100, 16'h0100, 32'h0001_0000}
  };

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  int       cycle = 0;
  int       data_errors = 0;
  int       latency_errors = 0;
  int       protocol_errors = 0;
  int       checked = 0;

  // Expected products and accept edges, in input order
  product_t exp_q[$];
  int       edge_q[$];

  mul16_top mul16_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic product_t expected_product(input operand_t x, input operand_t y);
    return product_t'(x) * product_t'(y);
  endfunction

  task automatic drive_pair(input operand_t a_val, input operand_t b_val,
                            input product_t expected);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= a_val;
    b        <= b_val;
    exp_q.push_back(expected);
  endtask

  // Operands change during gaps, nothing may be accepted
  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
    a        <= operand_t'($urandom());
    b        <= operand_t'($urandom());
  endtask

  task automatic check_result();
    product_t expected;
    int       accepted_at;
    assert (edge_q.size() != 0 && exp_q.size() != 0) else begin
      $display("A result appeared at time %0t with no pair in flight", $time);
      protocol_errors++;
    end
    if (edge_q.size() != 0 && exp_q.size() != 0) begin
      expected    = exp_q.pop_front();
      accepted_at = edge_q.pop_front();
      checked++;
      assert (product === expected) else begin
        $display("FAIL %0t: product %h, expected %h", $time, product, expected);
        data_errors++;
      end
      // Consumer takes the result at the next rising edge
      assert (cycle + 1 == accepted_at + LATENCY) else begin
        $display("FAIL %0t: result after %0d cycles, expected %0d", $time,
                 cycle + 1 - accepted_at, LATENCY);
        latency_errors++;
      end
    end
  endtask

  // Sample between edges, where outputs are stable
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!out_valid) else begin
        $display("out_valid was high during reset at time %0t", $time);
        protocol_errors++;
      end
    end else begin
      if (out_valid) begin
        check_result();
      end
      // Pair seen now is sampled at the next rising edge
      if (in_valid) begin
        edge_q.push_back(cycle + 1);
      end
    end
  end

  initial begin
    operand_t a_val;
    operand_t b_val;

    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    void'($urandom(32'h98c6_6f23));

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_VECTORS; i++) begin
      drive_pair(vectors[i][63:48], vectors[i][47:32], vectors[i][31:0]);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      a_val = operand_t'($urandom());
      b_val = operand_t'($urandom());
      drive_pair(a_val, b_val, expected_product(a_val, b_val));
    end
    idle_cycle();

    // Drain the pipeline, then a few quiet cycles to catch stray results
    repeat (LATENCY + 4) @(negedge clk);

    assert (exp_q.size() == 0 && edge_q.size() == 0) else begin
      $display("%0d expected results never appeared", exp_q.size());
      protocol_errors++;
    end

    $display("Errors: data %0d, latency %0d, protocol %0d, results checked %0d",
             data_errors, latency_errors, protocol_errors, checked);
    if (data_errors + latency_errors + protocol_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/mul16_pkg.sv
rtl/mul8_array.sv
rtl/cla_adder32.sv
rtl/partial_product_stage.sv
rtl/product_sum_stage.sv
rtl/mul16_top.sv
verif/mul16_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mul16_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
